/* Makefile */
TOP = tb_axi2ahb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wall -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Some tests failed" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "All tests passed" sim.log || { echo "FAIL"; exit 1; }

clean:
	rm -rf obj_dir sim.log

/* source/ahb_master_fsm.sv */
// Command take and AHB-Lite address/data phase FSM with response build

`timescale 1ns/1ns

module ahb_master_fsm (
  input  logic                         buf_clk,
  input  logic                         rst_l,
  input  axi_pkg::axi_cmd_t            cmd,
  input  logic                         cmd_valid,
  input  logic                         rsp_busy,
  output logic                         cmd_take,
  output logic                         idle,
  output ahb_pkg::ahb_req_t            ahb_req,
  output logic [ahb_pkg::HDATA_W-1:0]  hwdata,
  input  logic [ahb_pkg::HDATA_W-1:0]  hrdata,
  input  logic                         hready,
  input  logic                         hresp,
  output axi_pkg::axi_rsp_t            rsp,
  output logic                         rsp_load
);

  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_ADDR = 2'd1,
    S_DATA = 2'd2
  } state_e;

  state_e            state_q;
  state_e            state_d;
  axi_pkg::axi_cmd_t cmd_q;
  logic [2:0]        wr_size;
  logic [2:0]        wr_offset;

  ////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////

  // No new command while a response is still waiting
  assign cmd_take = (state_q == S_IDLE) & cmd_valid & ~rsp_busy;
  assign idle     = (state_q == S_IDLE);
  assign rsp_load = (state_q == S_DATA) & hready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (cmd_take) state_d = S_ADDR;
      end
      S_ADDR: begin
        if (hready) state_d = S_DATA;
      end
      S_DATA: begin
        if (hready) state_d = S_IDLE;
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge buf_clk or negedge rst_l) begin
    if (!rst_l) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge buf_clk) begin
    if (cmd_take) begin
      cmd_q <= cmd;
    end
  end

  ////////////////////////////////////////////////////////////
  // Address phase
  ////////////////////////////////////////////////////////////

  // Writes take size and low address bits from the strobe
  assign wr_size   = axi_pkg::strb_size(cmd_q.strb, cmd_q.size);
  assign wr_offset = axi_pkg::strb_offset(cmd_q.strb);

  always_comb begin
    ahb_req.htrans = (state_q == S_ADDR) ? ahb_pkg::NONSEQ : ahb_pkg::IDLE;
    ahb_req.hwrite = cmd_q.write;
    if (cmd_q.write) begin
      ahb_req.haddr = {cmd_q.addr[axi_pkg::ADDR_W-1:3], wr_offset};
      ahb_req.hsize = ahb_pkg::hsize_e'(wr_size);
    end else begin
      ahb_req.haddr = cmd_q.addr;
      ahb_req.hsize = ahb_pkg::hsize_e'(cmd_q.size);
    end
    // Privileged, non-bufferable, non-cacheable; bit 0 marks data access
    ahb_req.hprot = {3'b001, ~cmd_q.prot[2]};
  end

  ////////////////////////////////////////////////////////////
  // Data phase and response
  ////////////////////////////////////////////////////////////

  assign hwdata = cmd_q.data;

  always_comb begin
    rsp.id    = cmd_q.id;
    rsp.write = cmd_q.write;
    if (hresp) begin
      rsp.resp = axi_pkg::SLVERR;
      rsp.data = '0;
    end else begin
      rsp.resp = axi_pkg::OKAY;
      rsp.data = cmd_q.write ? '0 : hrdata;
    end
  end

endmodule

/* source/ahb_pkg.sv */
// AHB-Lite bus widths, transfer-type and size codes, address-phase request struct

package ahb_pkg;

  localparam int HADDR_W = 32;
  localparam int HDATA_W = 64;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    NONSEQ = 2'b10
  } htrans_e;

  typedef enum logic [2:0] {
    BYTE  = 3'd0,
    HALF  = 3'd1,
    WORD  = 3'd2,
    DWORD = 3'd3
  } hsize_e;

  // Address and control of one transfer
  typedef struct packed {
    htrans_e            htrans;
    logic [HADDR_W-1:0] haddr;
    logic               hwrite;
    hsize_e             hsize;
    logic [3:0]         hprot;
  } ahb_req_t;

endpackage

/* source/axi2ahb_bridge.sv */
// AXI to AHB-Lite bridge top level with command mux and read accept term

`timescale 1ns/1ns

module axi2ahb_bridge (
  input  logic                        buf_clk,
  input  logic                        rst_l,
  input  axi_pkg::axi_addr_t          aw,
  input  logic                        aw_valid,
  output logic                        aw_ready,
  input  axi_pkg::axi_w_t             w,
  input  logic                        w_valid,
  output logic                        w_ready,
  input  axi_pkg::axi_addr_t          ar,
  input  logic                        ar_valid,
  output logic                        ar_ready,
  output logic [axi_pkg::ID_W-1:0]    b_id,
  output axi_pkg::axi_resp_e          b_resp,
  output logic                        b_valid,
  input  logic                        b_ready,
  output logic [axi_pkg::ID_W-1:0]    r_id,
  output axi_pkg::axi_resp_e          r_resp,
  output logic [axi_pkg::DATA_W-1:0]  r_data,
  output logic                        r_last,
  output logic                        r_valid,
  input  logic                        r_ready,
  output ahb_pkg::ahb_req_t           ahb_req,
  output logic [ahb_pkg::HDATA_W-1:0] hwdata,
  input  logic [ahb_pkg::HDATA_W-1:0] hrdata,
  input  logic                        hready,
  input  logic                        hresp
);

  logic               wr_cmd_valid;
  axi_pkg::axi_addr_t wr_addr;
  axi_pkg::axi_w_t    wr_data;
  axi_pkg::axi_cmd_t  cmd;
  logic               cmd_take;
  logic               fsm_idle;
  axi_pkg::axi_rsp_t  rsp;
  logic               rsp_load;
  logic               rsp_busy;

  axi_write_buffer u_wbuf (
    .buf_clk      (buf_clk),
    .rst_l        (rst_l),
    .aw           (aw),
    .aw_valid     (aw_valid),
    .aw_ready     (aw_ready),
    .w            (w),
    .w_valid      (w_valid),
    .w_ready      (w_ready),
    .wr_release   (cmd_take & cmd.write),
    .wr_cmd_valid (wr_cmd_valid),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data)
  );

  ////////////////////////////////////////////////////////////
  // Command mux
  ////////////////////////////////////////////////////////////

  // A complete write wins over AR
  always_comb begin
    if (wr_cmd_valid) begin
      cmd = '{id: wr_addr.id, addr: wr_addr.addr, size: wr_addr.size,
              prot: wr_addr.prot, write: 1'b1, data: wr_data.data, strb: wr_data.strb};
    end else begin
      cmd = '{id: ar.id, addr: ar.addr, size: ar.size,
              prot: ar.prot, write: 1'b0, data: '0, strb: '0};
    end
  end

  // AR handshake lines up with cmd_take for a read
  assign ar_ready = fsm_idle & ~rsp_busy & ~wr_cmd_valid;

  ahb_master_fsm u_fsm (
    .buf_clk   (buf_clk),
    .rst_l     (rst_l),
    .cmd       (cmd),
    .cmd_valid (wr_cmd_valid | ar_valid),
    .rsp_busy  (rsp_busy),
    .cmd_take  (cmd_take),
    .idle      (fsm_idle),
    .ahb_req   (ahb_req),
    .hwdata    (hwdata),
    .hrdata    (hrdata),
    .hready    (hready),
    .hresp     (hresp),
    .rsp       (rsp),
    .rsp_load  (rsp_load)
  );

  axi_resp_buffer u_rbuf (
    .buf_clk  (buf_clk),
    .rst_l    (rst_l),
    .rsp      (rsp),
    .rsp_load (rsp_load),
    .rsp_busy (rsp_busy),
    .b_id     (b_id),
    .b_resp   (b_resp),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .r_id     (r_id),
    .r_resp   (r_resp),
    .r_data   (r_data),
    .r_last   (r_last),
    .r_valid  (r_valid),
    .r_ready  (r_ready)
  );

endmodule

/* source/axi_pkg.sv */
// AXI field widths, beat and command structs, response codes, strobe decode functions

package axi_pkg;

  localparam int ID_W   = 4;
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int STRB_W = 8;

  // Shared by the AW and AR channels
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [2:0]        size;
    logic [2:0]        prot;
  } axi_addr_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axi_w_t;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  // Command selected from the write entry or the AR channel
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [2:0]        size;
    logic [2:0]        prot;
    logic              write;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axi_cmd_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    axi_resp_e         resp;
    logic [DATA_W-1:0] data;
    logic              write;
  } axi_rsp_t;

  // Transfer size from an aligned strobe pattern, AW size otherwise
  function automatic logic [2:0] strb_size(logic [STRB_W-1:0] strb, logic [2:0] size);
    case (strb)
      8'hff:                      return 3'd3;
      8'hf0, 8'h0f:               return 3'd2;
      8'hc0, 8'h30, 8'h0c, 8'h03: return 3'd1;
      default:                    return size;
    endcase
  endfunction

  // Byte offset of the lowest enabled lane
  function automatic logic [2:0] strb_offset(logic [STRB_W-1:0] strb);
    case (strb)
      8'h0c:        return 3'd2;
      8'hf0, 8'h30: return 3'd4;
      8'hc0:        return 3'd6;
      default:      return 3'd0;
    endcase
  endfunction

endpackage

/* source/axi_resp_buffer.sv */
// One-entry response holding register steered to the AXI B or R channel

`timescale 1ns/1ns

module axi_resp_buffer (
  input  logic                        buf_clk,
  input  logic                        rst_l,
  input  axi_pkg::axi_rsp_t           rsp,
  input  logic                        rsp_load,
  output logic                        rsp_busy,
  output logic [axi_pkg::ID_W-1:0]    b_id,
  output axi_pkg::axi_resp_e          b_resp,
  output logic                        b_valid,
  input  logic                        b_ready,
  output logic [axi_pkg::ID_W-1:0]    r_id,
  output axi_pkg::axi_resp_e          r_resp,
  output logic [axi_pkg::DATA_W-1:0]  r_data,
  output logic                        r_last,
  output logic                        r_valid,
  input  logic                        r_ready
);

  axi_pkg::axi_rsp_t rsp_q;
  logic              full;
  logic              drain;

  assign drain = (b_valid & b_ready) | (r_valid & r_ready);

  always_ff @(posedge buf_clk or negedge rst_l) begin
    if (!rst_l) begin
      full <= 1'b0;
    end else if (rsp_load) begin
      full <= 1'b1;
    end else if (drain) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge buf_clk) begin
    if (rsp_load) begin
      rsp_q <= rsp;
    end
  end

  assign rsp_busy = full;

  // Steer by the write flag
  assign b_valid = full & rsp_q.write;
  assign b_id    = rsp_q.id;
  assign b_resp  = rsp_q.resp;

  assign r_valid = full & ~rsp_q.write;
  assign r_id    = rsp_q.id;
  assign r_resp  = rsp_q.resp;
  assign r_data  = rsp_q.data;
  assign r_last  = r_valid;   // single-beat reads only

endmodule

/* source/axi_write_buffer.sv */
// One-entry AW and W holding registers with their ready signals

`timescale 1ns/1ns

module axi_write_buffer (
  input  logic               buf_clk,
  input  logic               rst_l,
  input  axi_pkg::axi_addr_t aw,
  input  logic               aw_valid,
  output logic               aw_ready,
  input  axi_pkg::axi_w_t    w,
  input  logic               w_valid,
  output logic               w_ready,
  input  logic               wr_release,
  output logic               wr_cmd_valid,
  output axi_pkg::axi_addr_t wr_addr,
  output axi_pkg::axi_w_t    wr_data
);

  logic aw_full;
  logic w_full;

  // Each slot takes a beat only while empty
  assign aw_ready     = ~aw_full;
  assign w_ready      = ~w_full;
  assign wr_cmd_valid = aw_full & w_full;

  always_ff @(posedge buf_clk or negedge rst_l) begin
    if (!rst_l) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
    end else if (wr_release) begin
      aw_full <= 1'b0;
      w_full  <= 1'b0;
    end else begin
      if (aw_valid && aw_ready) aw_full <= 1'b1;
      if (w_valid && w_ready)   w_full  <= 1'b1;
    end
  end

  // Beat payloads
  always_ff @(posedge buf_clk) begin
    if (aw_valid && aw_ready) begin
      wr_addr <= aw;
    end
    if (w_valid && w_ready) begin
      wr_data <= w;
    end
  end

endmodule

/* tb.f */
source/axi_pkg.sv
source/ahb_pkg.sv
source/axi_write_buffer.sv
source/ahb_master_fsm.sv
source/axi_resp_buffer.sv
source/axi2ahb_bridge.sv
verification/axi2ahb_sva.sv
verification/tb_axi2ahb.sv

/* verification/axi2ahb_sva.sv */
// Bound assertions on write strobe legality, AHB request stability, NONSEQ window and read hold

`timescale 1ns/1ns

module axi2ahb_sva (
  input logic              buf_clk,
  input logic              rst_l,
  input axi_pkg::axi_cmd_t cmd,
  input logic              cmd_take,
  input ahb_pkg::ahb_req_t ahb_req,
  input logic              hready,
  input logic              r_valid,
  input logic              r_ready
);

  // Only aligned strobe patterns reach the bus
  strb_legal: assert property (@(posedge buf_clk) disable iff (!rst_l)
    cmd_take && cmd.write |-> cmd.strb inside {8'hff, 8'hf0, 8'h0f, 8'hc0, 8'h30, 8'h0c, 8'h03})
    else $error("write strobe pattern %h is not aligned", cmd.strb);

  // Address phase held while the slave stretches it
  req_stable: assert property (@(posedge buf_clk) disable iff (!rst_l)
    ahb_req.htrans == ahb_pkg::NONSEQ && !hready |=> $stable(ahb_req))
    else $error("AHB request changed during a stretched address phase");

  // NONSEQ opens on an accept and lasts until the slave takes the address
  nonseq_window: assert property (@(posedge buf_clk) disable iff (!rst_l)
    ahb_req.htrans == ahb_pkg::NONSEQ |->
      $past(cmd_take) || $past(ahb_req.htrans == ahb_pkg::NONSEQ && !hready))
    else $error("NONSEQ driven outside the address phase");

  // Read response held until the master takes it
  r_hold: assert property (@(posedge buf_clk) disable iff (!rst_l)
    r_valid && !r_ready |=> r_valid)
    else $error("r_valid dropped before r_ready");

endmodule

bind axi2ahb_bridge axi2ahb_sva u_sva (
  .buf_clk  (buf_clk),
  .rst_l    (rst_l),
  .cmd      (cmd),
  .cmd_take (cmd_take),
  .ahb_req  (ahb_req),
  .hready   (hready),
  .r_valid  (r_valid),
  .r_ready  (r_ready)
);

/* verification/tb_axi2ahb.sv */
// Testbench with clock, reset, AHB slave model, LCG, compare tasks and directed tests

`timescale 1ns/1ns

module tb_axi2ahb;

  localparam int MAX_WAIT       = 3;
  localparam int NUM_TESTS      = 6;
  localparam int XFERS_PER_TEST = 12;
  localparam int CYCLE_LIMIT    = NUM_TESTS * XFERS_PER_TEST * (MAX_WAIT + 10);

  logic buf_clk;
  logic rst_l;
  axi_pkg::axi_addr_t aw;
  logic aw_valid;
  logic aw_ready;
  axi_pkg::axi_w_t w;
  logic w_valid;
  logic w_ready;
  axi_pkg::axi_addr_t ar;
  logic ar_valid;
  logic ar_ready;
  logic [3:0] b_id;
  axi_pkg::axi_resp_e b_resp;
  logic b_valid;
  logic b_ready;
  logic [3:0] r_id;
  axi_pkg::axi_resp_e r_resp;
  logic [63:0] r_data;
  logic r_last;
  logic r_valid;
  logic r_ready;
  ahb_pkg::ahb_req_t ahb_req;
  logic [63:0] hwdata;
  logic [63:0] hrdata;
  logic hready;
  logic hresp;

  // Slave model state
  logic [63:0] mem [0:255];
  logic dp_active = 1'b0;
  logic [31:0] dp_addr;
  logic dp_write;
  logic [2:0] dp_size;
  int xfer_count = 0;
  int seen_count = 0;
  int wait_left = 0;
  ahb_pkg::ahb_req_t last_req;
  ahb_pkg::ahb_req_t req_log[$];
  logic [31:0] lcg_state = 32'h3402;
  int cycles = 0;

  axi2ahb_bridge dut (.*);

  initial begin
    buf_clk = 1'b0;
    forever #4 buf_clk = ~buf_clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  ////////////////////////////////////////////////////////////
  // AHB slave model
  ////////////////////////////////////////////////////////////

  always @(posedge buf_clk) begin
    int lo;
    int nb;
    lo = dp_addr[2:0];
    nb = 1 << dp_size;
    if (dp_active && hready) begin
      if (dp_write && !dp_addr[31]) begin
        for (int b = 0; b < 8; b++) begin
          if (b >= lo && b < lo + nb) mem[dp_addr[10:3]][b*8 +: 8] = hwdata[b*8 +: 8];
        end
      end
      dp_active <= 1'b0;
    end
    if (ahb_req.htrans == ahb_pkg::NONSEQ && hready) begin
      dp_active  <= 1'b1;
      dp_addr    <= ahb_req.haddr;
      dp_write   <= ahb_req.hwrite;
      dp_size    <= ahb_req.hsize;
      last_req   <= ahb_req;
      req_log.push_back(ahb_req);
      xfer_count <= xfer_count + 1;
    end
  end

  // Wait states only in the data phase
  always @(negedge buf_clk) begin
    if (dp_active) begin
      if (xfer_count != seen_count) begin
        seen_count = xfer_count;
        wait_left  = (lcg_next() >> 16) % (MAX_WAIT + 1);
      end
      if (wait_left != 0) begin
        hready <= 1'b0;
        hresp  <= 1'b0;
        wait_left--;
      end else begin
        hready <= 1'b1;
        hresp  <= dp_addr[31];
        hrdata <= dp_addr[31] ? 64'hbad0_bad0_bad0_bad0 : mem[dp_addr[10:3]];
      end
    end else begin
      hready <= 1'b1;
      hresp  <= 1'b0;
    end
  end

  always @(posedge buf_clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: no progress within %0d cycles", CYCLE_LIMIT);
      $display("Some tests failed");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_resp(string name, axi_pkg::axi_resp_e got, axi_pkg::axi_resp_e exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %s exp %s", $time, name, got.name(), exp.name());
      stop_run();
    end
  endtask

  task automatic check_data(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_id(string name, logic [3:0] got, logic [3:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_req(string name, ahb_pkg::ahb_req_t got, ahb_pkg::ahb_req_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b exp %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // AXI drivers
  ////////////////////////////////////////////////////////////

  task automatic send_aw(axi_pkg::axi_addr_t a);
    @(negedge buf_clk);
    aw = a;
    aw_valid = 1'b1;
    while (!aw_ready) @(negedge buf_clk);
    @(negedge buf_clk);
    aw_valid = 1'b0;
  endtask

  task automatic send_w(axi_pkg::axi_w_t d);
    @(negedge buf_clk);
    w = d;
    w_valid = 1'b1;
    while (!w_ready) @(negedge buf_clk);
    @(negedge buf_clk);
    w_valid = 1'b0;
  endtask

  task automatic send_ar(axi_pkg::axi_addr_t a);
    @(negedge buf_clk);
    ar = a;
    ar_valid = 1'b1;
    while (!ar_ready) @(negedge buf_clk);
    @(negedge buf_clk);
    ar_valid = 1'b0;
  endtask

  // order 0 sends both beats together, 1 sends W first, 2 sends AW first
  task automatic do_write(logic [3:0] id, logic [31:0] addr, logic [63:0] data,
                          logic [7:0] strb, int order);
    axi_pkg::axi_addr_t a;
    axi_pkg::axi_w_t d;
    a = '{id: id, addr: addr, size: 3'd3, prot: 3'b000};
    d = '{data: data, strb: strb};
    if (order == 1) begin
      send_w(d);
      send_aw(a);
    end else if (order == 2) begin
      send_aw(a);
      send_w(d);
    end else begin
      fork
        send_aw(a);
        send_w(d);
      join
    end
  endtask

  task automatic wait_b(logic [3:0] id, axi_pkg::axi_resp_e resp);
    @(negedge buf_clk);
    b_ready = 1'b1;
    while (!b_valid) @(negedge buf_clk);
    check_id("b_id", b_id, id);
    check_resp("b_resp", b_resp, resp);
    @(negedge buf_clk);
    b_ready = 1'b0;
  endtask

  task automatic wait_r(logic [3:0] id, axi_pkg::axi_resp_e resp, logic [63:0] data);
    @(negedge buf_clk);
    r_ready = 1'b1;
    while (!r_valid) @(negedge buf_clk);
    check_id("r_id", r_id, id);
    check_resp("r_resp", r_resp, resp);
    check_data("r_data", r_data, data);
    check_bit("r_last", r_last, 1'b1);
    @(negedge buf_clk);
    r_ready = 1'b0;
  endtask

  task automatic do_read(logic [3:0] id, logic [31:0] addr, axi_pkg::axi_resp_e resp,
                         logic [63:0] data);
    send_ar('{id: id, addr: addr, size: 3'd3, prot: 3'b000});
    wait_r(id, resp, data);
  endtask

  function automatic logic [63:0] merge_bytes(logic [63:0] old, logic [63:0] nw,
                                              logic [7:0] strb);
    logic [63:0] res;
    res = old;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) res[b*8 +: 8] = nw[b*8 +: 8];
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    @(negedge buf_clk);
    check_bit("htrans_idle", ahb_req.htrans == ahb_pkg::IDLE, 1'b1);
    check_bit("b_valid", b_valid, 1'b0);
    check_bit("r_valid", r_valid, 1'b0);
    check_bit("aw_ready", aw_ready, 1'b1);
    check_bit("w_ready", w_ready, 1'b1);
    check_bit("ar_ready", ar_ready, 1'b1);
  endtask

  task automatic test_full_word();
    logic [63:0] data;
    data = {lcg_next(), lcg_next()};
    do_write(4'h3, 32'h0000_0040, data, 8'hff, 0);
    wait_b(4'h3, axi_pkg::OKAY);
    check_req("ahb_req", last_req, '{htrans: ahb_pkg::NONSEQ, haddr: 32'h0000_0040,
              hwrite: 1'b1, hsize: ahb_pkg::DWORD, hprot: 4'b0011});
    do_read(4'h5, 32'h0000_0040, axi_pkg::OKAY, data);
  endtask

  task automatic test_partial_writes();
    logic [7:0] strbs [3];
    ahb_pkg::hsize_e sizes [3];
    logic [2:0] offsets [3];
    logic [63:0] old;
    logic [63:0] data;
    int n;
    // Expected size and low address bits for each strobe
    strbs   = '{8'h0f, 8'hc0, 8'h30};
    sizes   = '{ahb_pkg::WORD, ahb_pkg::HALF, ahb_pkg::HALF};
    offsets = '{3'd0, 3'd6, 3'd4};
    foreach (strbs[i]) begin
      old  = mem[8'h20];
      data = {lcg_next(), lcg_next()};
      n    = xfer_count;
      do_write(4'h6, 32'h0000_0100, data, strbs[i], 0);
      wait_b(4'h6, axi_pkg::OKAY);
      check_data("xfer_count", xfer_count, n + 1);
      check_req("ahb_req", last_req, '{htrans: ahb_pkg::NONSEQ,
                haddr: {29'h0000_0020, offsets[i]}, hwrite: 1'b1,
                hsize: sizes[i], hprot: 4'b0011});
      do_read(4'h7, 32'h0000_0100, axi_pkg::OKAY, merge_bytes(old, data, strbs[i]));
    end
  endtask

  task automatic test_beat_order();
    int n;
    for (int order = 1; order <= 2; order++) begin
      n = xfer_count;
      do_write(4'h8 + order, 32'h0000_0080, 64'h1122_3344_5566_7788 + order, 8'hff, order);
      wait_b(4'h8 + order, axi_pkg::OKAY);
      repeat (3) @(negedge buf_clk);
      check_data("xfer_count", xfer_count, n + 1);
    end
  endtask

  task automatic test_bus_error();
    do_read(4'hc, 32'h8000_0010, axi_pkg::SLVERR, 64'h0);
    do_write(4'hd, 32'h8000_0020, 64'hffff_0000_ffff_0000, 8'hff, 0);
    wait_b(4'hd, axi_pkg::SLVERR);
  endtask

  // Responses held back, then a write and a read waiting together
  task automatic test_backpressure();
    int n0;
    n0 = xfer_count;
    do_write(4'h1, 32'h0000_0200, 64'haaaa_bbbb_cccc_dddd, 8'hff, 0);
    while (!b_valid) @(negedge buf_clk);
    do_write(4'h2, 32'h0000_0208, 64'h0123_4567_89ab_cdef, 8'hff, 0);
    ar = '{id: 4'h4, addr: 32'h0000_0208, size: 3'd3, prot: 3'b000};
    ar_valid = 1'b1;
    repeat (5) begin
      @(negedge buf_clk);
      check_bit("ar_ready", ar_ready, 1'b0);
      check_bit("b_valid", b_valid, 1'b1);
      check_data("xfer_count", xfer_count, n0 + 1);
    end
    wait_b(4'h1, axi_pkg::OKAY);
    wait_b(4'h2, axi_pkg::OKAY);
    while (!ar_ready) @(negedge buf_clk);
    @(negedge buf_clk);
    ar_valid = 1'b0;
    // A complete write waits behind the held read response
    do_write(4'h5, 32'h0000_0210, 64'h0fed_cba9_8765_4321, 8'hff, 0);
    while (!r_valid) @(negedge buf_clk);
    repeat (4) begin
      @(negedge buf_clk);
      check_bit("r_valid", r_valid, 1'b1);
      check_data("xfer_count", xfer_count, n0 + 3);
    end
    wait_r(4'h4, axi_pkg::OKAY, 64'h0123_4567_89ab_cdef);
    wait_b(4'h5, axi_pkg::OKAY);
    check_bit("second_hwrite", req_log[n0 + 1].hwrite, 1'b1);
    check_bit("third_hwrite", req_log[n0 + 2].hwrite, 1'b0);
  endtask

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = {32'hc0de_0000 | i, ~(32'h1000_0000 + i * 7)};
    end
    rst_l    = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    b_ready  = 1'b0;
    r_ready  = 1'b0;
    hrdata   = '0;
    hready   = 1'b1;
    hresp    = 1'b0;
    repeat (2) @(posedge buf_clk);
    @(negedge buf_clk);
    rst_l = 1'b1;
    test_reset_values();
    test_full_word();
    test_partial_writes();
    test_beat_order();
    test_bus_error();
    test_backpressure();
    $display("All tests passed");
    $finish;
  end

endmodule
